//--- rom_bus_pkg.sv
////////////////////////////////////////
// rom bus widths and vector types
////////////////////////////////////////
`default_nettype none

package rom_bus_pkg;

    // cpu rom address space, 64 kB
    localparam int unsigned ROM_AW = 16;

    // byte wide rom data
    localparam int unsigned ROM_DW = 8;

    // rom address as seen by the cpu and on the wishbone side
    typedef logic [ROM_AW-1:0] rom_addr_t;

    // one rom data word
    typedef logic [ROM_DW-1:0] rom_data_t;

endpackage

`default_nettype wire

//--- cpu_timing_pkg.sv
////////////////////////////////////////
// timing types for the cpu wait unit
// miss counter type and its ceiling
// fetch state machine encoding
////////////////////////////////////////
`default_nettype none

package cpu_timing_pkg;

    ////////////////////////////////////////
    // cycle recovery

    // width of the missed-pulse counter
    localparam int unsigned MISS_W = 4;

    // recoverable missed enable pulses
    typedef logic [MISS_W-1:0] miss_cnt_t;

    // counter saturates here, older misses are dropped
    localparam miss_cnt_t MISS_MAX = '1;

    ////////////////////////////////////////
    // rom fetch state machine
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_BUS  = 2'd1,
        FETCH_DONE = 2'd2
    } fetch_state_t;

endpackage

`default_nettype wire

//--- rom_req_if.sv
////////////////////////////////////////
// cpu rom request bundle
// fetcher and wait controller views
////////////////////////////////////////
`default_nettype none

interface rom_req_if
    import rom_bus_pkg::*;
();

    // cpu side request
    logic      cs;
    rom_addr_t addr;

    // answer from the fetcher
    logic      ok;
    rom_data_t data;

    // fetcher sees the request and returns data
    modport fetch (input cs, input addr, output ok, output data);

    // wait controller only needs select and ready
    modport waiter (input cs, input ok);

endinterface

`default_nettype wire

//--- cen_divider.sv
////////////////////////////////////////
// cpu clock enable divider
////////////////////////////////////////
`default_nettype none

module cen_divider #(
    parameter int unsigned DIV = 4
) (
    input  logic clk,
    input  logic rst_n,
    output logic cen_in
);

    // counter width follows the division ratio
    localparam int unsigned CW = $clog2(DIV);

    typedef logic [CW-1:0] div_cnt_t;

    // reload value, counts DIV-1 down to zero
    localparam div_cnt_t RELOAD = div_cnt_t'(DIV - 1);

    div_cnt_t cnt;

    // free running down-counter
    // pulse is registered so it lands DIV clocks after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= RELOAD;
            cen_in <= 1'b0;
        end else begin
            // one clock wide enable on terminal count
            cen_in <= (cnt == '0);
            if (cnt == '0) begin
                cnt <= RELOAD;
            end else begin
                cnt <= cnt - div_cnt_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- rom_fetch.sv
////////////////////////////////////////
// one word rom cache
// wishbone classic read master on a miss
////////////////////////////////////////
`default_nettype none

module rom_fetch
    import rom_bus_pkg::*;
    import cpu_timing_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    rom_req_if.fetch  req,
    output logic      wb_cyc,
    output logic      wb_stb,
    output rom_addr_t wb_adr,
    input  rom_data_t wb_dat,
    input  logic      wb_ack
);

    fetch_state_t state;

    // cached word and its tag
    logic      valid;
    rom_addr_t cache_addr;
    rom_data_t cache_data;

    logic hit;
    logic miss;

    ////////////////////////////////////////
    // hit detection

    // tag compare against the live cpu address
    assign hit  = valid && (req.addr == cache_addr);
    assign miss = req.cs && !hit;

    // data is ready as long as the cpu stays on the cached word
    assign req.ok   = req.cs && hit;
    assign req.data = cache_data;

    ////////////////////////////////////////
    // wishbone master

    // cyc and stb both follow the bus state, one read per cycle
    assign wb_cyc = (state == FETCH_BUS);
    assign wb_stb = (state == FETCH_BUS);

    // state and valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH_IDLE;
            valid <= 1'b0;
        end else begin
            unique case (state)
                FETCH_IDLE: begin
                    // miss opens the bus on the next clock
                    if (miss) begin
                        state <= FETCH_BUS;
                    end
                end
                FETCH_BUS: begin
                    // wait as long as the slave needs
                    if (wb_ack) begin
                        valid <= 1'b1;
                        state <= FETCH_DONE;
                    end
                end
                FETCH_DONE: begin
                    // cache now holds the new word
                    state <= FETCH_IDLE;
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // address and data registers
    always_ff @(posedge clk) begin
        // address is captured once and held through the cycle
        if (state == FETCH_IDLE && miss) begin
            wb_adr <= req.addr;
        end
        // fill the cache on the ack clock
        if (state == FETCH_BUS && wb_ack) begin
            cache_addr <= wb_adr;
            cache_data <= wb_dat;
        end
    end

endmodule

`default_nettype wire

//--- cpu_wait.sv
////////////////////////////////////////
// cpu enable gating on rom and bus waits
// missed pulse counter, cycle recovery
////////////////////////////////////////
`default_nettype none

module cpu_wait
    import cpu_timing_pkg::*;
#(
    parameter int unsigned DEVCNT   = 2,
    parameter bit          RECOVERY = 1'b1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen_in,
    input  logic              rec_en,
    input  logic [DEVCNT-1:0] dev_busy,
    rom_req_if.waiter         req,
    output logic              cen_out,
    output logic              gate
);

    logic      last_cs;
    logic      cs_rise;
    logic      rom_bad;
    logic      busy;
    logic      locked;
    logic      started;
    logic      cen_l;
    logic      rec;
    miss_cnt_t miss_cnt;

    ////////////////////////////////////////
    // wait detection

    // a fresh select is never served in its first clock
    assign cs_rise = req.cs && !last_cs;
    assign rom_bad = (req.cs && !req.ok) || cs_rise;

    // any shared device holding the bus
    assign busy = |dev_busy;

    // locked stretches every wait by one clock
    assign gate = !(rom_bad || busy || locked);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // select already high at reset is not a new request
            last_cs <= 1'b1;
            locked  <= 1'b0;
            started <= 1'b0;
        end else begin
            last_cs <= req.cs;
            locked  <= rom_bad || busy;
            // first clear clock arms the miss counter
            if (!(rom_bad || busy)) begin
                started <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // cycle recovery

    // extra pulse only between regular pulses
    // never right after another enable
    assign rec = RECOVERY && rec_en && (miss_cnt != '0) && !cen_in && !cen_l;

    // gated enable plus recovery pulses
    assign cen_out = (cen_in && gate) || rec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_l <= 1'b0;
        end else begin
            cen_l <= cen_out;
        end
    end

    // busy stalls are lost on purpose, only rom waits count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            miss_cnt <= '0;
        end else if (!started) begin
            miss_cnt <= '0;
        end else if (cen_in && !gate && !busy) begin
            // saturate, extra misses are dropped
            if (miss_cnt != MISS_MAX) begin
                miss_cnt <= miss_cnt + miss_cnt_t'(1);
            end
        end else if (rec) begin
            miss_cnt <= miss_cnt - miss_cnt_t'(1);
        end
    end

endmodule

`default_nettype wire

//--- cpu_clk_top.sv
////////////////////////////////////////
// cpu clock enable and rom wait top
////////////////////////////////////////
`default_nettype none

module cpu_clk_top
    import rom_bus_pkg::*;
#(
    parameter int unsigned DIV      = 4,
    parameter int unsigned DEVCNT   = 2,
    parameter bit          RECOVERY = 1'b1
) (
    input  logic              clk,
    input  logic              rst_n,
    // cpu rom port
    input  logic              cpu_rom_cs,
    input  rom_addr_t         cpu_rom_addr,
    output rom_data_t         cpu_rom_data,
    // wait and enable control
    input  logic              rec_en,
    input  logic [DEVCNT-1:0] dev_busy,
    output logic              cen_out,
    output logic              gate,
    // wishbone classic read master
    output logic              wb_cyc,
    output logic              wb_stb,
    output rom_addr_t         wb_adr,
    input  rom_data_t         wb_dat,
    input  logic              wb_ack
);

    logic cen_in;

    // rom request shared by fetcher and wait controller
    rom_req_if u_rom_req ();

    assign u_rom_req.cs   = cpu_rom_cs;
    assign u_rom_req.addr = cpu_rom_addr;
    assign cpu_rom_data   = u_rom_req.data;

    // base enable from the system clock
    cen_divider #(
        .DIV (DIV)
    ) u_cen_divider (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen_in (cen_in)
    );

    rom_fetch u_rom_fetch (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (u_rom_req.fetch),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_adr (wb_adr),
        .wb_dat (wb_dat),
        .wb_ack (wb_ack)
    );

    cpu_wait #(
        .DEVCNT   (DEVCNT),
        .RECOVERY (RECOVERY)
    ) u_cpu_wait (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen_in   (cen_in),
        .rec_en   (rec_en),
        .dev_busy (dev_busy),
        .req      (u_rom_req.waiter),
        .cen_out  (cen_out),
        .gate     (gate)
    );

endmodule

`default_nettype wire

//--- cpu_clk_props.sv
////////////////////////////////////////
// wishbone and enable properties
// bound into the cpu clock top
////////////////////////////////////////
`default_nettype none

module cpu_clk_props
    import rom_bus_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      wb_cyc,
    input logic      wb_stb,
    input rom_addr_t wb_adr,
    input logic      wb_ack,
    input logic      cen_out,
    input logic      gate,
    input logic      rec_en
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed properties so far
    int fail_cnt = 0;

    // strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb high without wb_cyc");
            fail_cnt++;
        end

    // address held until the slave answers
    adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
                                 wb_cyc && !wb_ack |=> $stable(wb_adr))
        else begin
            $error("wb_adr changed during a cycle");
            fail_cnt++;
        end

    // single read, cycle ends the clock after ack
    cyc_ends: assert property (@(posedge clk) disable iff (!rst_n)
                               wb_cyc && wb_ack |=> !wb_cyc)
        else begin
            $error("wb_cyc still high after ack");
            fail_cnt++;
        end

    no_adjacent_cen: assert property (@(posedge clk) disable iff (!rst_n)
                                      cen_out |=> !cen_out)
        else begin
            $error("cen_out on two consecutive clocks");
            fail_cnt++;
        end

    // only recovery pulses pass a closed gate
    gated_cen: assert property (@(posedge clk) disable iff (!rst_n)
                                !gate && cen_out |-> rec_en)
        else begin
            $error("cen_out with gate low and rec_en low");
            fail_cnt++;
        end

endmodule

bind cpu_clk_top cpu_clk_props u_cpu_clk_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_adr  (wb_adr),
    .wb_ack  (wb_ack),
    .cen_out (cen_out),
    .gate    (gate),
    .rec_en  (rec_en)
);

`default_nettype wire

//--- tb_cpu_clk.sv
////////////////////////////////////////
// testbench for the cpu clock enable top
// wishbone memory model, directed tests
// pulse bookkeeping, watchdog, summary
////////////////////////////////////////
`default_nettype none

module tb_cpu_clk
    import rom_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DIV        = 4;
    localparam int DEVCNT     = 2;
    localparam int CLK_PERIOD = 20;

    // worst case clocks per test
    // the watchdog allows twice the sum
    localparam int MISS_CLKS  = 22;
    localparam int REC_CLKS   = 8 * MISS_CLKS + 4 + DIV + 4 * 15 * DIV;
    localparam int TOTAL_CLKS = 2 + 40 + MISS_CLKS + 8 + REC_CLKS + 13 * DIV + REC_CLKS + 51;

    logic              clk;
    logic              rst_n;
    logic              cpu_rom_cs;
    rom_addr_t         cpu_rom_addr;
    rom_data_t         cpu_rom_data;
    logic              rec_en;
    logic [DEVCNT-1:0] dev_busy;
    logic              cen_out;
    logic              gate;
    logic              wb_cyc;
    logic              wb_stb;
    rom_addr_t         wb_adr;
    rom_data_t         wb_dat;
    logic              wb_ack;

    // bookkeeping updated on the rising edge
    int          clk_cnt      = 0;
    int          exp_cnt      = 0;
    int          out_cnt      = 0;
    int          gate_low_cnt = 0;
    int          wb_cycles    = 0;
    rom_addr_t   wb_first_adr = '0;
    logic        cyc_q        = 1'b0;
    int          err_cnt      = 0;
    int          chk_cnt      = 0;
    int unsigned lcg_state    = 22;
    int unsigned ack_delay;

    cpu_clk_top #(
        .DIV      (DIV),
        .DEVCNT   (DEVCNT),
        .RECOVERY (1'b1)
    ) u_cpu_clk_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_rom_cs   (cpu_rom_cs),
        .cpu_rom_addr (cpu_rom_addr),
        .cpu_rom_data (cpu_rom_data),
        .rec_en       (rec_en),
        .dev_busy     (dev_busy),
        .cen_out      (cen_out),
        .gate         (gate),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_dat       (wb_dat),
        .wb_ack       (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // memory model and pulse counters

    function int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // slave acks 1 to 6 clocks after it sees the cycle
    initial begin
        wb_ack = 1'b0;
        wb_dat = '0;
        forever begin
            @(negedge clk);
            wb_ack = 1'b0;
            if (wb_cyc && wb_stb) begin
                ack_delay = 1 + next_rand() % 6;
                repeat (ack_delay - 1) @(negedge clk);
                wb_dat = rom_data_t'(wb_adr[7:0]) ^ 8'h5A;
                wb_ack = 1'b1;
            end
        end
    end

    // one expected enable every DIV clocks
    // first one DIV clocks after reset
    always @(posedge clk) begin
        if (rst_n) begin
            clk_cnt++;
            if (clk_cnt > DIV && (clk_cnt - 1) % DIV == 0)
                exp_cnt++;
            if (cen_out)
                out_cnt++;
            if (!gate)
                gate_low_cnt++;
            if (wb_cyc && !cyc_q) begin
                wb_cycles++;
                wb_first_adr = wb_adr;
            end
            cyc_q = wb_cyc;
        end
    end

    function int shortfall();
        return exp_cnt - out_cnt;
    endfunction

    ////////////////////////////////////////
    // helpers

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp)
        else begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: %0d errors", name, err_cnt - err_before);
    endtask

    // stop on the falling edge just before an expected enable
    task automatic align_to_pulse();
        do begin
            @(negedge clk);
        end while (clk_cnt % DIV != 0);
    endtask

    // miss on a new address with rec_en low
    task automatic fetch_new_word(input rom_addr_t a);
        int cycles_before;
        int waited;
        cpu_rom_cs = 1'b0;
        @(negedge clk);
        cycles_before = wb_cycles;
        cpu_rom_cs    = 1'b1;
        cpu_rom_addr  = a;
        waited        = 0;
        do begin
            @(negedge clk);
            waited++;
            if (!gate)
                expect_eq("cen_out", cen_out, 0);
        end while (!gate && waited < MISS_CLKS - 2);
        assert (gate && waited > 1)
        else begin
            $display("gate did not go low and come back after a ROM miss");
            err_cnt++;
        end
        expect_eq("wb_cycles", wb_cycles - cycles_before, 1);
        expect_eq("wb_adr", wb_first_adr, a);
        expect_eq("cpu_rom_data", cpu_rom_data, a[7:0] ^ 8'h5A);
    endtask

    // wait for the shortfall to drop to a target level
    task automatic wait_shortfall(input int target, input int limit);
        int waited;
        waited = 0;
        while (shortfall() != target && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        expect_eq("shortfall", shortfall(), target);
    endtask

    ////////////////////////////////////////
    // directed tests

    task automatic idle_after_reset();
        int err_before;
        int last_pulse;
        int pulses;
        err_before = err_cnt;
        last_pulse = 0;
        pulses     = 0;
        for (int i = 1; i <= 40; i++) begin
            @(negedge clk);
            expect_eq("gate", gate, 1);
            expect_eq("wb_cyc", wb_cyc, 0);
            if (cen_out) begin
                expect_eq("cen_out spacing", i - last_pulse, DIV);
                last_pulse = i;
                pulses++;
            end
        end
        expect_eq("cen_out pulses", pulses, 40 / DIV);
        report_test("idle after reset", err_before);
    endtask

    task automatic first_miss(input rom_addr_t a);
        int err_before;
        err_before = err_cnt;
        fetch_new_word(a);
        report_test("rom miss", err_before);
    endtask

    // select dropped and raised on the cached word
    task automatic cached_hit(input rom_addr_t a);
        int err_before;
        int cycles_before;
        int low_before;
        err_before    = err_cnt;
        cycles_before = wb_cycles;
        cpu_rom_cs    = 1'b0;
        repeat (3) @(negedge clk);
        low_before   = gate_low_cnt;
        cpu_rom_cs   = 1'b1;
        cpu_rom_addr = a;
        repeat (4) @(negedge clk);
        // rise clock plus locked clock
        expect_eq("gate low clocks", gate_low_cnt - low_before, 2);
        expect_eq("wb_cycles", wb_cycles - cycles_before, 0);
        expect_eq("cpu_rom_data", cpu_rom_data, a[7:0] ^ 8'h5A);
        report_test("rom hit", err_before);
    endtask

    task automatic pulse_recovery();
        int err_before;
        int tries;
        int n;
        err_before = err_cnt;
        rec_en     = 1'b0;
        tries      = 0;
        do begin
            fetch_new_word(rom_addr_t'(32'h1200 + tries * 32'h111));
            tries++;
        end while (shortfall() < 1 && tries < 8);
        cpu_rom_cs = 1'b0;
        repeat (2) @(negedge clk);
        n = shortfall();
        assert (n >= 1 && n <= 15)
        else begin
            $display("miss did not swallow between 1 and 15 enable pulses");
            err_cnt++;
        end
        align_to_pulse();
        rec_en = 1'b1;
        wait_shortfall(0, 4 * n * DIV);
        report_test("cycle recovery", err_before);
    endtask

    // busy losses stay lost even with recovery on
    task automatic busy_stall();
        int err_before;
        int base;
        int exp_before;
        int busy_exp;
        err_before = err_cnt;
        rec_en     = 1'b1;
        @(negedge clk);
        base                 = shortfall();
        exp_before           = exp_cnt;
        dev_busy[DEVCNT-1]   = 1'b1;
        repeat (5 * DIV) @(negedge clk);
        busy_exp = exp_cnt - exp_before;
        dev_busy = '0;
        repeat (8 * DIV) @(negedge clk);
        expect_eq("shortfall", shortfall() - base, busy_exp);
        report_test("busy stall", err_before);
    endtask

    task automatic recovery_hold_off();
        int err_before;
        int base;
        int held;
        int tries;
        err_before = err_cnt;
        rec_en     = 1'b0;
        base       = shortfall();
        tries      = 0;
        do begin
            fetch_new_word(rom_addr_t'(32'h3400 + tries * 32'h123));
            tries++;
        end while (shortfall() == base && tries < 8);
        cpu_rom_cs = 1'b0;
        @(negedge clk);
        held = shortfall();
        repeat (50) @(negedge clk);
        expect_eq("held shortfall", shortfall(), held);
        align_to_pulse();
        rec_en = 1'b1;
        wait_shortfall(base, 4 * (held - base) * DIV);
        report_test("recovery held off", err_before);
    endtask

    ////////////////////////////////////////
    // sequence, watchdog and summary

    initial begin
        rst_n        = 1'b0;
        cpu_rom_cs   = 1'b0;
        cpu_rom_addr = '0;
        rec_en       = 1'b0;
        dev_busy     = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        first_miss(16'h0A37);
        cached_hit(16'h0A37);
        pulse_recovery();
        busy_stall();
        recovery_hold_off();
        $display("checks %0d errors %0d props %0d cen_out %0d expected %0d wb cycles %0d",
                 chk_cnt, err_cnt, u_cpu_clk_top.u_cpu_clk_props.fail_cnt,
                 out_cnt, exp_cnt, wb_cycles);
        if (err_cnt == 0 && u_cpu_clk_top.u_cpu_clk_props.fail_cnt == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin
        #(TOTAL_CLKS * 2 * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rom_bus_pkg.sv
cpu_timing_pkg.sv
rom_req_if.sv
cen_divider.sv
rom_fetch.sv
cpu_wait.sv
cpu_clk_top.sv
cpu_clk_props.sv
tb_cpu_clk.sv
